// File: hdl/sched_cfg_pkg.sv
package sched_cfg_pkg;

   // --------------------------------------------------
   // Default sizes of the scheduler
   // --------------------------------------------------

   // Descriptor slots in the layer queue
   localparam int QUEUE_DEPTH = 8;

   // Weight pipeline stages fed by the scheduler
   localparam int PIPE_DEPTH = 2;

   // Cycles from a finished tile until the layer counts as written back
   localparam int WRITEBACK_DELAY = 3;

   // Output channels of the full compute array
   localparam int N_O_MAX = 128;

   // --------------------------------------------------
   // Activation memory
   // --------------------------------------------------

   // Two bank sets alternate between read and write
   typedef logic bank_t;

endpackage

// File: hdl/layer_pkg.sv
package layer_pkg;

   // --------------------------------------------------
   // Field widths of a layer descriptor
   // --------------------------------------------------

   localparam int DIM_W    = 9;
   localparam int K_W      = 3;
   localparam int CH_W     = 8;
   localparam int STRIDE_W = 2;

   // Image width or height in pixels
   typedef logic [DIM_W-1:0] dim_t;

   // Kernel size
   typedef logic [K_W-1:0] k_t;

   // Input or output channel count
   typedef logic [CH_W-1:0] ch_t;

   // --------------------------------------------------
   // Layer descriptor
   // --------------------------------------------------

   typedef struct packed {
      dim_t                img_w;
      dim_t                img_h;
      k_t                  k;
      ch_t                 ni;
      ch_t                 no;
      logic [STRIDE_W-1:0] stride_w;
      logic [STRIDE_W-1:0] stride_h;
      logic                pad_type;  // 0 for valid, 1 for same
   } layer_t;

endpackage

// File: hdl/layer_queue.sv
`timescale 1ns/1ps

module layer_queue #(
   parameter int QUEUE_DEPTH = sched_cfg_pkg::QUEUE_DEPTH
) (
   input  logic                             clk_i,
   input  logic                             rst_ni,

   input  logic                             store_req_i,
   input  layer_pkg::layer_t                layer_i,
   output logic                             store_ack_o,

   input  logic                             run_active_i,
   input  logic                             pop_i,

   output layer_pkg::layer_t                head_o,
   output logic [$clog2(QUEUE_DEPTH)-1:0]   head_ptr_o,
   output logic [$clog2(QUEUE_DEPTH+1)-1:0] layer_count_o
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = $clog2(QUEUE_DEPTH+1);

   layer_pkg::layer_t mem_q [QUEUE_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] head_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             ack_q;
   logic             full;
   logic             push;
   logic             head_wraps;

   assign full = (count_q == CNT_W'(QUEUE_DEPTH));

   // New request only, slot free and no run playing the list
   assign push = store_req_i && !ack_q && !full && !run_active_i;

   // The head wraps over the stored layers, not over all slots
   assign head_wraps = ((CNT_W'(head_ptr_q) + CNT_W'(1)) == count_q);

   assign store_ack_o   = ack_q;
   assign head_o        = mem_q[head_ptr_q];
   assign head_ptr_o    = head_ptr_q;
   assign layer_count_o = count_q;

   // --------------------------------------------------
   // Load handshake and pointers
   // --------------------------------------------------

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         ack_q      <= 1'b0;
         wr_ptr_q   <= '0;
         head_ptr_q <= '0;
         count_q    <= '0;
      end else begin
         if (push) begin
            ack_q    <= 1'b1;
            count_q  <= count_q + CNT_W'(1);
            wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH-1)) ? '0 : wr_ptr_q + PTR_W'(1);
         end else if (ack_q && !store_req_i) begin
            ack_q <= 1'b0;
         end

         // Popped entry stays in place so the list replays
         if (pop_i && count_q != '0) begin
            head_ptr_q <= head_wraps ? '0 : head_ptr_q + PTR_W'(1);
         end
      end
   end

   // Descriptor storage
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= layer_i;
      end
   end

endmodule

// File: hdl/writeback_timer.sv
`timescale 1ns/1ps

module writeback_timer #(
   parameter int WRITEBACK_DELAY = sched_cfg_pkg::WRITEBACK_DELAY
) (
   input  logic clk_i,
   input  logic rst_ni,

   input  logic layer_running_i,
   input  logic latch_i,
   input  logic tilebuffer_done_i,
   input  logic weightload_done_i,

   output logic layer_done_o
);

   localparam int CNT_W = $clog2(WRITEBACK_DELAY+1);

   logic [CNT_W-1:0] cnt_q;
   logic             busy_q;
   logic             done_q;
   logic             start;

   // Only the first qualifying edge of a layer starts the delay
   assign start = layer_running_i && tilebuffer_done_i && weightload_done_i &&
                  !busy_q && !done_q;

   assign layer_done_o = done_q;

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_q  <= '0;
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end else if (latch_i) begin
         cnt_q  <= '0;
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end else if (start) begin
         cnt_q  <= CNT_W'(WRITEBACK_DELAY-1);
         busy_q <= 1'b1;
      end else if (busy_q) begin
         if (cnt_q == '0) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end else begin
            cnt_q <= cnt_q - CNT_W'(1);
         end
      end
   end

endmodule

// File: hdl/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer #(
   parameter int QUEUE_DEPTH = sched_cfg_pkg::QUEUE_DEPTH
) (
   input  logic                             clk_i,
   input  logic                             rst_ni,

   input  logic                             run_i,

   input  logic [$clog2(QUEUE_DEPTH+1)-1:0] layer_count_i,
   input  layer_pkg::layer_t                head_i,
   input  logic                             layer_done_i,

   output logic                             pop_o,
   output logic                             run_active_o,
   output logic                             layer_running_o,
   output logic                             first_layer_o,

   output logic                             compute_latch_new_layer_o,
   output logic                             compute_soft_reset_o,
   output layer_pkg::layer_t                compute_layer_o,

   output sched_cfg_pkg::bank_t             readbank_o,
   output sched_cfg_pkg::bank_t             writebank_o,

   output logic                             compute_done_o
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH+1);

   // FSM encoding
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_LATCH = 2'd1;
   localparam logic [1:0] ST_RUN   = 2'd2;
   localparam logic [1:0] ST_HOLD  = 2'd3;

   logic [1:0]           state_q;
   logic [1:0]           state_d;
   logic [CNT_W-1:0]     idx_q;
   logic [CNT_W-1:0]     idx_d;
   layer_pkg::layer_t    cur_layer_q;
   sched_cfg_pkg::bank_t readbank_q;
   sched_cfg_pkg::bank_t writebank_q;

   logic start_run;
   logic last_layer;
   logic next_layer;

   assign start_run  = (state_q == ST_IDLE) && run_i && (layer_count_i != '0);
   assign last_layer = ((idx_q + CNT_W'(1)) == layer_count_i);
   assign next_layer = (state_q == ST_RUN) && layer_done_i && !last_layer;

   // --------------------------------------------------
   // Control outputs
   // --------------------------------------------------

   assign pop_o           = start_run || next_layer;
   assign run_active_o    = (state_q != ST_IDLE) || run_i;
   assign layer_running_o = (state_q == ST_RUN);
   assign first_layer_o   = (idx_q == '0);

   assign compute_latch_new_layer_o = (state_q == ST_LATCH);
   assign compute_soft_reset_o      = compute_latch_new_layer_o && first_layer_o;
   assign compute_done_o            = (state_q == ST_RUN) && layer_done_i && last_layer;

   assign compute_layer_o = cur_layer_q;
   assign readbank_o      = readbank_q;
   assign writebank_o     = writebank_q;

   // Index of the layer being popped
   assign idx_d = start_run ? '0 : idx_q + CNT_W'(1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start_run) begin
               state_d = ST_LATCH;
            end
         end
         ST_LATCH: state_d = ST_RUN;
         ST_RUN: begin
            if (next_layer) begin
               state_d = ST_LATCH;
            end else if (compute_done_o) begin
               state_d = ST_HOLD;
            end
         end
         // Wait for run_i to drop before another run
         default: begin
            if (!run_i) begin
               state_d = ST_IDLE;
            end
         end
      endcase
   end

   // --------------------------------------------------
   // State, current layer and banks
   // --------------------------------------------------

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         state_q     <= ST_IDLE;
         idx_q       <= '0;
         cur_layer_q <= '0;
         readbank_q  <= 1'b1;
         writebank_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (pop_o) begin
            idx_q       <= idx_d;
            cur_layer_q <= head_i;
            // Even layers read set 0 and write set 1
            readbank_q  <= idx_d[0];
            writebank_q <= !idx_d[0];
         end
      end
   end

endmodule

// File: hdl/weight_stage_ctrl.sv
`timescale 1ns/1ps

module weight_stage_ctrl #(
   parameter int PIPE_DEPTH = sched_cfg_pkg::PIPE_DEPTH
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,

   input  logic                  pop_i,
   input  logic                  weightload_done_i,

   input  layer_pkg::ch_t        current_no_i,
   input  layer_pkg::ch_t        next_no_i,
   input  logic                  next_is_first_i,

   output logic [PIPE_DEPTH-1:0] weights_latch_new_layer_o,
   output logic [PIPE_DEPTH-1:0] weights_soft_reset_o,
   output logic [PIPE_DEPTH-1:0] weights_toggle_banks_o
);

   // Output channels handled by one stage
   localparam int CH_PER_STAGE = sched_cfg_pkg::N_O_MAX / PIPE_DEPTH;

   logic pop_q;
   logic ready_q;
   logic fire;

   // Lowest stages active, enough of them to cover the channels
   function automatic logic [PIPE_DEPTH-1:0] stage_mask(input layer_pkg::ch_t no);
      int n_active;
      logic [PIPE_DEPTH-1:0] mask;
      n_active = (int'(no) + CH_PER_STAGE - 1) / CH_PER_STAGE;
      for (int i = 0; i < PIPE_DEPTH; i++) begin
         mask[i] = (i < n_active);
      end
      return mask;
   endfunction

   assign fire = ready_q && weightload_done_i;

   assign weights_toggle_banks_o    = pop_q ? stage_mask(current_no_i) : '0;
   assign weights_latch_new_layer_o = fire ? stage_mask(next_no_i) : '0;
   assign weights_soft_reset_o      = next_is_first_i ? weights_latch_new_layer_o : '0;

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         pop_q   <= 1'b0;
         ready_q <= 1'b0;
      end else begin
         pop_q <= pop_i;
         if (pop_i) begin
            ready_q <= 1'b1;
         end else if (fire) begin
            ready_q <= 1'b0;
         end
      end
   end

endmodule

// File: hdl/layer_sched_top.sv
`timescale 1ns/1ps

module layer_sched_top #(
   parameter int QUEUE_DEPTH     = sched_cfg_pkg::QUEUE_DEPTH,
   parameter int PIPE_DEPTH      = sched_cfg_pkg::PIPE_DEPTH,
   parameter int WRITEBACK_DELAY = sched_cfg_pkg::WRITEBACK_DELAY
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,

   // Descriptor load
   input  logic                  store_req_i,
   input  layer_pkg::layer_t     layer_i,
   output logic                  store_ack_o,

   // Run control and status from the datapath
   input  logic                  run_i,
   input  logic                  tilebuffer_done_i,
   input  logic                  weightload_done_i,

   // Compute array
   output layer_pkg::layer_t     compute_layer_o,
   output logic                  compute_latch_new_layer_o,
   output logic                  compute_soft_reset_o,

   // Activation bank sets
   output sched_cfg_pkg::bank_t  readbank_o,
   output sched_cfg_pkg::bank_t  writebank_o,

   // Weight pipeline stages
   output logic [PIPE_DEPTH-1:0] weights_latch_new_layer_o,
   output logic [PIPE_DEPTH-1:0] weights_soft_reset_o,
   output logic [PIPE_DEPTH-1:0] weights_toggle_banks_o,

   output logic                  compute_done_o
);

   layer_pkg::layer_t                head;
   logic [$clog2(QUEUE_DEPTH)-1:0]   head_ptr;
   logic [$clog2(QUEUE_DEPTH+1)-1:0] layer_count;
   logic                             pop;
   logic                             run_active;
   logic                             layer_running;
   logic                             layer_done;
   logic                             next_is_first;

   // Head back at slot 0 means the prefetch is the first layer again
   assign next_is_first = (head_ptr == '0);

   layer_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_layer_queue (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .store_req_i   (store_req_i),
      .layer_i       (layer_i),
      .store_ack_o   (store_ack_o),
      .run_active_i  (run_active),
      .pop_i         (pop),
      .head_o        (head),
      .head_ptr_o    (head_ptr),
      .layer_count_o (layer_count)
   );

   layer_sequencer #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_layer_sequencer (
      .clk_i                     (clk_i),
      .rst_ni                    (rst_ni),
      .run_i                     (run_i),
      .layer_count_i             (layer_count),
      .head_i                    (head),
      .layer_done_i              (layer_done),
      .pop_o                     (pop),
      .run_active_o              (run_active),
      .layer_running_o           (layer_running),
      .first_layer_o             (),
      .compute_latch_new_layer_o (compute_latch_new_layer_o),
      .compute_soft_reset_o      (compute_soft_reset_o),
      .compute_layer_o           (compute_layer_o),
      .readbank_o                (readbank_o),
      .writebank_o               (writebank_o),
      .compute_done_o            (compute_done_o)
   );

   writeback_timer #(
      .WRITEBACK_DELAY (WRITEBACK_DELAY)
   ) i_writeback_timer (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .layer_running_i   (layer_running),
      .latch_i           (compute_latch_new_layer_o),
      .tilebuffer_done_i (tilebuffer_done_i),
      .weightload_done_i (weightload_done_i),
      .layer_done_o      (layer_done)
   );

   weight_stage_ctrl #(
      .PIPE_DEPTH (PIPE_DEPTH)
   ) i_weight_stage_ctrl (
      .clk_i                     (clk_i),
      .rst_ni                    (rst_ni),
      .pop_i                     (pop),
      .weightload_done_i         (weightload_done_i),
      .current_no_i              (compute_layer_o.no),
      .next_no_i                 (head.no),
      .next_is_first_i           (next_is_first),
      .weights_latch_new_layer_o (weights_latch_new_layer_o),
      .weights_soft_reset_o      (weights_soft_reset_o),
      .weights_toggle_banks_o    (weights_toggle_banks_o)
   );

endmodule

// File: tb/tb_layer_model.svh
`ifndef TB_LAYER_MODEL_SVH
`define TB_LAYER_MODEL_SVH

// --------------------------------------------------
// Reference model of the layer list
// --------------------------------------------------

// Descriptors in load order
layer_pkg::layer_t loaded_q[$];

// Layer on the compute array, -1 outside a run
int cur_idx = -1;

// Set at each latch, cleared when the weight latch for the prefetch fires
logic prefetch_pending = 1'b0;

layer_pkg::layer_t    exp_layer     = '0;
sched_cfg_pkg::bank_t exp_readbank  = 1'b1;
sched_cfg_pkg::bank_t exp_writebank = 1'b0;

// Stage s is needed while channels remain beyond the first s stages
function automatic logic [PIPE_DEPTH-1:0] expected_stage_mask(input layer_pkg::ch_t no);
   logic [PIPE_DEPTH-1:0] mask;
   int                    per_stage;
   per_stage = sched_cfg_pkg::N_O_MAX / PIPE_DEPTH;
   for (int s = 0; s < PIPE_DEPTH; s++) begin
      mask[s] = (int'(no) > s * per_stage);
   end
   return mask;
endfunction

task automatic record_load(input layer_pkg::layer_t l);
   loaded_q.push_back(l);
endtask

// Next layer goes onto the compute array
task automatic begin_layer();
   if (cur_idx + 1 >= loaded_q.size()) begin
      $display("Compute latch seen after the last loaded layer of the run");
      abort_run();
   end
   cur_idx          = cur_idx + 1;
   exp_layer        = loaded_q[cur_idx];
   exp_readbank     = (cur_idx % 2) != 0;
   exp_writebank    = (cur_idx % 2) == 0;
   prefetch_pending = 1'b1;
endtask

// The layer after the current one, wrapping to the start of the list
function automatic int prefetch_index();
   return (cur_idx + 1) % loaded_q.size();
endfunction

task automatic end_run();
   cur_idx = -1;
endtask

`endif

// File: tb/tb_layer_sched.sv
`timescale 1ns/1ps

module tb_layer_sched;

   localparam int QUEUE_DEPTH     = sched_cfg_pkg::QUEUE_DEPTH;
   localparam int PIPE_DEPTH      = sched_cfg_pkg::PIPE_DEPTH;
   localparam int WRITEBACK_DELAY = sched_cfg_pkg::WRITEBACK_DELAY;
   localparam int WAIT_LIMIT      = 20;

   logic                  clk_i;
   logic                  rst_ni;
   logic                  store_req_i;
   layer_pkg::layer_t     layer_i;
   logic                  store_ack_o;
   logic                  run_i;
   logic                  tilebuffer_done_i;
   logic                  weightload_done_i;
   layer_pkg::layer_t     compute_layer_o;
   logic                  compute_latch_new_layer_o;
   logic                  compute_soft_reset_o;
   sched_cfg_pkg::bank_t  readbank_o;
   sched_cfg_pkg::bank_t  writebank_o;
   logic [PIPE_DEPTH-1:0] weights_latch_new_layer_o;
   logic [PIPE_DEPTH-1:0] weights_soft_reset_o;
   logic [PIPE_DEPTH-1:0] weights_toggle_banks_o;
   logic                  compute_done_o;

   integer seed;

   layer_sched_top #(
      .QUEUE_DEPTH     (QUEUE_DEPTH),
      .PIPE_DEPTH      (PIPE_DEPTH),
      .WRITEBACK_DELAY (WRITEBACK_DELAY)
   ) i_layer_sched_top (
      .clk_i                     (clk_i),
      .rst_ni                    (rst_ni),
      .store_req_i               (store_req_i),
      .layer_i                   (layer_i),
      .store_ack_o               (store_ack_o),
      .run_i                     (run_i),
      .tilebuffer_done_i         (tilebuffer_done_i),
      .weightload_done_i         (weightload_done_i),
      .compute_layer_o           (compute_layer_o),
      .compute_latch_new_layer_o (compute_latch_new_layer_o),
      .compute_soft_reset_o      (compute_soft_reset_o),
      .readbank_o                (readbank_o),
      .writebank_o               (writebank_o),
      .weights_latch_new_layer_o (weights_latch_new_layer_o),
      .weights_soft_reset_o      (weights_soft_reset_o),
      .weights_toggle_banks_o    (weights_toggle_banks_o),
      .compute_done_o            (compute_done_o)
   );

   initial clk_i = 1'b0;
   always #5 clk_i = ~clk_i;

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_layer(input string what, input layer_pkg::layer_t act,
                              input layer_pkg::layer_t exp);
      if (act !== exp) begin
         $display("ERROR %0t ns: %s expected %h, got %h", $time, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bank(input string what, input sched_cfg_pkg::bank_t act,
                             input sched_cfg_pkg::bank_t exp);
      if (act !== exp) begin
         $display("ERROR %0t ns: %s expected %b, got %b", $time, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_mask(input string what, input logic [PIPE_DEPTH-1:0] act,
                             input logic [PIPE_DEPTH-1:0] exp);
      if (act !== exp) begin
         $display("ERROR %0t ns: %s expected %b, got %b", $time, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string what, input logic act, input logic exp);
      if (act !== exp) begin
         $display("ERROR %0t ns: %s expected %b, got %b", $time, what, exp, act);
         abort_run();
      end
   endtask

   `include "tb_layer_model.svh"

   // --------------------------------------------------
   // Random stimulus
   // --------------------------------------------------

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   function automatic layer_pkg::layer_t random_layer();
      layer_pkg::layer_t l;
      logic [31:0]       r;
      r = $random(seed);
      l.img_w    = r[8:0];
      l.img_h    = r[17:9];
      l.k        = r[20:18];
      l.ni       = r[28:21];
      l.stride_w = r[30:29];
      l.pad_type = r[31];
      r = $random(seed);
      l.stride_h = r[9:8];
      // At least one output channel so every latch mask is visible
      l.no = (r[7:0] == 8'd0) ? 8'd1 : r[7:0];
      return l;
   endfunction

   // Cycles in which neither a latch nor a done pulse may appear
   task automatic quiet_cycles(input int n);
      repeat (n) begin
         @(negedge clk_i);
         check_bit("compute_latch_new_layer_o while waiting", compute_latch_new_layer_o, 1'b0);
         check_bit("compute_done_o while waiting", compute_done_o, 1'b0);
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic load_layer(input layer_pkg::layer_t l);
      int waited;
      @(posedge clk_i);
      #1;
      store_req_i = 1'b1;
      layer_i     = l;
      waited      = 0;
      @(negedge clk_i);
      while (!store_ack_o) begin
         if (waited == WAIT_LIMIT) begin
            $display("Timeout waiting for store_ack_o to rise after a store request");
            abort_run();
         end
         waited++;
         @(negedge clk_i);
      end
      record_load(l);
      @(posedge clk_i);
      #1;
      store_req_i = 1'b0;
      // Bus data is no longer valid once req drops
      layer_i     = random_layer();
      waited      = 0;
      @(negedge clk_i);
      while (store_ack_o) begin
         if (waited == WAIT_LIMIT) begin
            $display("Timeout waiting for store_ack_o to fall after the request dropped");
            abort_run();
         end
         waited++;
         @(negedge clk_i);
      end
   endtask

   // Entered at the negedge of a latch cycle
   task automatic serve_layer(input logic last);
      logic weights_first;
      @(posedge clk_i);
      #1;
      tilebuffer_done_i = 1'b0;
      weightload_done_i = 1'b0;
      weights_first     = rand_below(2) == 1;
      quiet_cycles(rand_below(4));
      if (weights_first) begin
         weightload_done_i = 1'b1;
      end else begin
         tilebuffer_done_i = 1'b1;
      end
      quiet_cycles(rand_below(4));
      weightload_done_i = 1'b1;
      tilebuffer_done_i = 1'b1;
      // Timer starts on the next edge, then the fixed writeback delay runs
      for (int k = 1; k <= WRITEBACK_DELAY + 2; k++) begin
         @(negedge clk_i);
         check_bit("compute_latch_new_layer_o during writeback", compute_latch_new_layer_o,
                   1'b0);
         check_bit("compute_done_o at end of writeback", compute_done_o,
                   last && (k == WRITEBACK_DELAY + 2));
      end
      if (!last) begin
         @(negedge clk_i);
         check_bit("compute_latch_new_layer_o after writeback", compute_latch_new_layer_o, 1'b1);
      end
   endtask

   task automatic run_list();
      int waited;
      @(posedge clk_i);
      #1;
      run_i  = 1'b1;
      waited = 0;
      @(negedge clk_i);
      while (!compute_latch_new_layer_o) begin
         if (waited == WAIT_LIMIT) begin
            $display("Timeout waiting for the first compute latch of a run");
            abort_run();
         end
         check_bit("compute_done_o before the first layer", compute_done_o, 1'b0);
         waited++;
         @(negedge clk_i);
      end
      for (int n = 0; n < loaded_q.size(); n++) begin
         serve_layer(n == loaded_q.size() - 1);
      end
      @(posedge clk_i);
      #1;
      run_i             = 1'b0;
      tilebuffer_done_i = 1'b0;
      weightload_done_i = 1'b0;
      @(negedge clk_i);
      check_bit("compute_done_o after the run", compute_done_o, 1'b0);
      check_bit("compute_latch_new_layer_o after the run", compute_latch_new_layer_o, 1'b0);
   endtask

   task automatic check_reset_state();
      @(negedge clk_i);
      check_bit("store_ack_o after reset", store_ack_o, 1'b0);
      check_bit("compute_latch_new_layer_o after reset", compute_latch_new_layer_o, 1'b0);
      check_bit("compute_soft_reset_o after reset", compute_soft_reset_o, 1'b0);
      check_bit("compute_done_o after reset", compute_done_o, 1'b0);
      check_layer("compute_layer_o after reset", compute_layer_o, '0);
      check_bank("readbank_o after reset", readbank_o, 1'b1);
      check_bank("writebank_o after reset", writebank_o, 1'b0);
      check_mask("weights_latch_new_layer_o after reset", weights_latch_new_layer_o, '0);
      check_mask("weights_soft_reset_o after reset", weights_soft_reset_o, '0);
      check_mask("weights_toggle_banks_o after reset", weights_toggle_banks_o, '0);
   endtask

   // --------------------------------------------------
   // Output monitor
   // --------------------------------------------------

   always @(negedge clk_i) begin : monitor
      logic [PIPE_DEPTH-1:0] exp_toggle;
      logic [PIPE_DEPTH-1:0] exp_latch;
      logic [PIPE_DEPTH-1:0] exp_soft;
      int                    nxt;
      if (rst_ni) begin
         if (compute_latch_new_layer_o) begin
            begin_layer();
         end
         check_layer("compute_layer_o", compute_layer_o, exp_layer);
         check_bank("readbank_o", readbank_o, exp_readbank);
         check_bank("writebank_o", writebank_o, exp_writebank);
         check_bit("compute_soft_reset_o", compute_soft_reset_o,
                   compute_latch_new_layer_o && (cur_idx == 0));
         exp_toggle = compute_latch_new_layer_o ? expected_stage_mask(exp_layer.no) : '0;
         check_mask("weights_toggle_banks_o", weights_toggle_banks_o, exp_toggle);
         exp_latch = '0;
         exp_soft  = '0;
         // Weight latch goes out once the loader reports done after a pop
         if (prefetch_pending && weightload_done_i) begin
            nxt       = prefetch_index();
            exp_latch = expected_stage_mask(loaded_q[nxt].no);
            if (nxt == 0) begin
               exp_soft = exp_latch;
            end
            prefetch_pending = 1'b0;
         end
         check_mask("weights_latch_new_layer_o", weights_latch_new_layer_o, exp_latch);
         check_mask("weights_soft_reset_o", weights_soft_reset_o, exp_soft);
         if (compute_done_o) begin
            end_run();
         end
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------

   initial begin
      int n_layers;
      seed              = 32'ha38d_52c8;
      rst_ni            = 1'b0;
      store_req_i       = 1'b0;
      layer_i           = '0;
      run_i             = 1'b0;
      tilebuffer_done_i = 1'b0;
      weightload_done_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
      check_reset_state();

      n_layers = 2 + rand_below(QUEUE_DEPTH - 1);
      for (int i = 0; i < n_layers; i++) begin
         load_layer(random_layer());
      end

      // Same list twice, the queue recirculates
      run_list();
      quiet_cycles(rand_below(3));
      run_list();

      $display("TEST OK");
      $finish;
   end

endmodule

// File: sim.f
+incdir+tb
hdl/sched_cfg_pkg.sv
hdl/layer_pkg.sv
hdl/layer_queue.sv
hdl/writeback_timer.sv
hdl/layer_sequencer.sv
hdl/weight_stage_ctrl.sv
hdl/layer_sched_top.sv
tb/tb_layer_sched.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the layer scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module tb_layer_sched -f sim.f -o tb_layer_sched; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/tb_layer_sched > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation exited with an error status"
   exit 1
fi

cat "$LOG"

if grep -q "^TEST OK$" "$LOG"; then
   exit 0
fi

echo "Pass message not found in $LOG"
exit 1
